/* f2_pkg.sv */
`default_nettype none

package f2_pkg;

    //////////////////////////////////////////////////
    // Bus and port widths

    typedef logic [22:0] word_addr_t;   // 68000 word address, A23..A1
    typedef logic [15:0] bus_data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  lane_n_t;      // {uds_n, lds_n}
    typedef logic [9:0]  joy_t;

    typedef enum logic [1:0] {
        GAME_FINALB,
        GAME_GROWL,
        GAME_NINJAK
    } game_t;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_WORK,
        REGION_IO,
        REGION_IACK
    } region_t;

    //////////////////////////////////////////////////
    // Memory map, byte address bits 23..16

    localparam byte_t WORK_BASE_FINALB = 8'h10;
    localparam byte_t WORK_BASE_GROWL  = 8'h10;
    localparam byte_t WORK_BASE_NINJAK = 8'h20;

    localparam byte_t IO_BASE_FINALB = 8'h30;
    localparam byte_t IO_BASE_GROWL  = 8'h30;
    localparam byte_t IO_BASE_NINJAK = 8'hB0;

    localparam int WORK_AW = 15;    // 64 KB of work RAM

    // Function code of an interrupt acknowledge cycle
    localparam logic [2:0] FC_IACK = 3'd7;

    //////////////////////////////////////////////////
    // Input chip word offsets

    localparam logic [3:0] PORT_DSWA = 4'd0;
    localparam logic [3:0] PORT_DSWB = 4'd1;
    localparam logic [3:0] PORT_P1   = 4'd2;
    localparam logic [3:0] PORT_P2   = 4'd3;
    localparam logic [3:0] PORT_SYS  = 4'd4;

    // Interrupt levels
    localparam logic [2:0] IRQ_VBL_LEVEL = 3'd5;
    localparam logic [2:0] IRQ_DMA_LEVEL = 3'd6;

endpackage

`default_nettype wire

/* cpu_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Registered CPU cycle, fanned out to every target
interface cpu_bus_if;
    import f2_pkg::*;

    logic       start;      // One clock per bus cycle
    region_t    region;
    logic       rw;         // 1 = read
    lane_n_t    ds_n;
    word_addr_t waddr;
    bus_data_t  wdata;

    modport source (
        output start, region, rw, ds_n, waddr, wdata
    );

    modport target (
        input start, region, rw, ds_n, waddr, wdata
    );

endinterface

`default_nettype wire

/* region_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module region_decoder (
    input  logic               clk,
    input  logic               reset,
    input  logic               as_n,
    input  logic               rw,
    input  f2_pkg::lane_n_t    ds_n,
    input  f2_pkg::word_addr_t addr,
    input  logic [2:0]         fc,
    input  f2_pkg::bus_data_t  wdata,
    input  f2_pkg::game_t      game,
    cpu_bus_if.source          bus,
    output logic               cycle_active
);
    import f2_pkg::*;

    logic    as_prev;
    logic    new_cycle;
    byte_t   work_base;
    byte_t   io_base;
    byte_t   addr_hi;
    region_t region_next;

    assign new_cycle = as_prev & ~as_n;
    assign addr_hi   = addr[22:15];     // byte address bits 23..16

    always_comb begin
        case (game)
            GAME_GROWL: begin
                work_base = WORK_BASE_GROWL;
                io_base   = IO_BASE_GROWL;
            end
            GAME_NINJAK: begin
                work_base = WORK_BASE_NINJAK;
                io_base   = IO_BASE_NINJAK;
            end
            default: begin
                work_base = WORK_BASE_FINALB;
                io_base   = IO_BASE_FINALB;
            end
        endcase
    end

    always_comb begin
        if (fc == FC_IACK)
            region_next = REGION_IACK;
        else if (addr_hi == work_base)
            region_next = REGION_WORK;
        else if (addr_hi == io_base)
            region_next = REGION_IO;
        else
            region_next = REGION_NONE;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            as_prev      <= 1'b1;
            cycle_active <= 1'b0;
            bus.start    <= 1'b0;
            bus.region   <= REGION_NONE;
        end else begin
            as_prev   <= as_n;
            bus.start <= new_cycle;
            if (new_cycle) begin
                cycle_active <= 1'b1;
                bus.region   <= region_next;
            end else if (as_n) begin
                cycle_active <= 1'b0;   // CPU ended the cycle
            end
        end
    end

    // Cycle payload, held until the next start
    always_ff @(posedge clk) begin
        if (new_cycle) begin
            bus.rw    <= rw;
            bus.ds_n  <= ds_n;
            bus.waddr <= addr;
            bus.wdata <= wdata;
        end
    end

endmodule

`default_nettype wire

/* work_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module work_ram (
    input  logic              clk,
    cpu_bus_if.target         bus,
    output f2_pkg::bus_data_t q
);
    import f2_pkg::*;

    localparam int DEPTH = 2 ** WORK_AW;

    bus_data_t mem [DEPTH];

    logic [WORK_AW-1:0] ram_addr;
    logic               sel;
    logic               we_hi;
    logic               we_lo;

    assign ram_addr = bus.waddr[WORK_AW-1:0];
    assign sel      = bus.start && (bus.region == REGION_WORK);

    // Byte lanes, active-low strobes
    assign we_hi = sel & ~bus.rw & ~bus.ds_n[1];
    assign we_lo = sel & ~bus.rw & ~bus.ds_n[0];

    //////////////////////////////////////////////////
    // Upper and lower byte lanes

    always_ff @(posedge clk) begin
        if (we_hi) begin
            mem[ram_addr][15:8] <= bus.wdata[15:8];
        end
        if (we_lo) begin
            mem[ram_addr][7:0] <= bus.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            q <= mem[ram_addr];     // read-before-write on a write cycle
        end
    end

endmodule

`default_nettype wire

/* input_ports.sv */
`timescale 1ns/100ps
`default_nettype none

module input_ports (
    input  logic          clk,
    cpu_bus_if.target     bus,
    input  f2_pkg::game_t game,
    input  f2_pkg::joy_t  joystick_p1,
    input  f2_pkg::joy_t  joystick_p2,
    input  logic [1:0]    start,
    input  logic [1:0]    coin,
    input  f2_pkg::byte_t dswa,
    input  f2_pkg::byte_t dswb,
    output f2_pkg::byte_t q
);
    import f2_pkg::*;

    logic [3:0] ofs;
    logic       sel;
    byte_t      p1_byte;
    byte_t      p2_byte;
    byte_t      sys_byte;
    byte_t      port_byte;

    // Growl board has the lowest address line swapped
    assign ofs = (game == GAME_GROWL) ? {bus.waddr[3:1], ~bus.waddr[0]} : bus.waddr[3:0];
    assign sel = bus.start && (bus.region == REGION_IO);

    //////////////////////////////////////////////////
    // Packing, active high before inversion

    assign p1_byte = {start[0], joystick_p1[6:4],
                      joystick_p1[0], joystick_p1[1], joystick_p1[2], joystick_p1[3]};
    assign p2_byte = {start[1], joystick_p2[6:4],
                      joystick_p2[0], joystick_p2[1], joystick_p2[2], joystick_p2[3]};
    assign sys_byte = {2'b00, coin, start, 2'b00};

    always_comb begin
        case (ofs)
            PORT_DSWA: port_byte = ~dswa;
            PORT_DSWB: port_byte = ~dswb;
            PORT_P1:   port_byte = ~p1_byte;
            PORT_P2:   port_byte = ~p2_byte;
            PORT_SYS:  port_byte = ~sys_byte;
            default:   port_byte = 8'hFF;  // Nothing driven
        endcase
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            q <= port_byte;
        end
    end

endmodule

`default_nettype wire

/* irq_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl (
    input  logic       clk,
    input  logic       reset,
    cpu_bus_if.target  bus,
    input  logic       vblank_n,
    input  logic       dma_n,
    output logic [2:0] ipl_n
);
    import f2_pkg::*;

    logic vbl_prev;
    logic dma_prev;
    logic req_vbl;
    logic req_dma;
    logic iack;
    logic ack_vbl;
    logic ack_dma;

    assign iack    = bus.start && (bus.region == REGION_IACK);
    assign ack_vbl = iack && (bus.waddr[2:0] == IRQ_VBL_LEVEL);
    assign ack_dma = iack && (bus.waddr[2:0] == IRQ_DMA_LEVEL);

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_prev <= 1'b1;
            dma_prev <= 1'b1;
            req_vbl  <= 1'b0;
            req_dma  <= 1'b0;
        end else begin
            vbl_prev <= vblank_n;
            dma_prev <= dma_n;

            if (vbl_prev && !vblank_n) req_vbl <= 1'b1;    // Start of vblank
            if (!dma_prev && dma_n)    req_dma <= 1'b1;    // Object DMA done

            // Acknowledge beats a new edge
            if (ack_vbl) req_vbl <= 1'b0;
            if (ack_dma) req_dma <= 1'b0;
        end
    end

    always_comb begin
        if (req_dma)
            ipl_n = ~IRQ_DMA_LEVEL;
        else if (req_vbl)
            ipl_n = ~IRQ_VBL_LEVEL;
        else
            ipl_n = 3'b111;
    end

endmodule

`default_nettype wire

/* f2_bus_top.sv */
`timescale 1ns/100ps
`default_nettype none

module f2_bus_top (
    input  logic               clk,
    input  logic               reset,
    input  f2_pkg::game_t      game,

    // 68000 bus
    input  logic               as_n,
    input  logic               rw,
    input  f2_pkg::lane_n_t    ds_n,
    input  f2_pkg::word_addr_t addr,
    input  logic [2:0]         fc,
    input  f2_pkg::bus_data_t  wdata,
    output f2_pkg::bus_data_t  rdata,
    output logic               dtack_n,
    output logic [2:0]         ipl_n,

    // Player inputs
    input  f2_pkg::joy_t       joystick_p1,
    input  f2_pkg::joy_t       joystick_p2,
    input  logic [1:0]         start,
    input  logic [1:0]         coin,
    input  f2_pkg::byte_t      dswa,
    input  f2_pkg::byte_t      dswb,

    input  logic               vblank_n,
    input  logic               dma_n
);
    import f2_pkg::*;

    logic      cycle_active;
    bus_data_t work_q;
    byte_t     io_q;

    cpu_bus_if bus ();

    region_decoder u_decoder (
        .clk,
        .reset,
        .as_n,
        .rw,
        .ds_n,
        .addr,
        .fc,
        .wdata,
        .game,
        .bus          (bus),
        .cycle_active (cycle_active)
    );

    work_ram u_work_ram (
        .clk,
        .bus (bus),
        .q   (work_q)
    );

    input_ports u_input_ports (
        .clk,
        .bus (bus),
        .game,
        .joystick_p1,
        .joystick_p2,
        .start,
        .coin,
        .dswa,
        .dswb,
        .q   (io_q)
    );

    irq_ctrl u_irq_ctrl (
        .clk,
        .reset,
        .bus (bus),
        .vblank_n,
        .dma_n,
        .ipl_n
    );

    //////////////////////////////////////////////////
    // DTACK and read data

    // Every target answers one clock after the registered start
    always_ff @(posedge clk) begin
        if (reset) begin
            dtack_n <= 1'b1;
        end else begin
            dtack_n <= as_n | ~cycle_active;
        end
    end

    always_comb begin
        case (bus.region)
            REGION_WORK: rdata = work_q;
            REGION_IO:   rdata = {io_q, io_q};  // 8-bit chip on both lanes
            default:     rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* tb_f2_bus.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_f2_bus;
    import f2_pkg::*;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_PORT,
        OP_IACK,
        OP_VBL,
        OP_DMA
    } op_t;

    typedef struct packed {
        op_t        op;
        game_t      game;
        word_addr_t addr;
        lane_n_t    ds_n;
        bus_data_t  wdata;
        bus_data_t  expected;   // rdata or ipl_n in bits 2..0
    } entry_t;

    localparam int RESET_CYCLES = 5;
    localparam int DTACK_LIMIT  = 12;
    localparam int MAX_ENTRIES  = 40;
    localparam int MAX_CYCLES   = 2 * MAX_ENTRIES * DTACK_LIMIT + 40;

    logic       clk;
    logic       reset;
    game_t      game;
    logic       as_n;
    logic       rw;
    lane_n_t    ds_n;
    word_addr_t addr;
    logic [2:0] fc;
    bus_data_t  wdata;
    bus_data_t  rdata;
    logic       dtack_n;
    logic [2:0] ipl_n;
    joy_t       joystick_p1;
    joy_t       joystick_p2;
    logic [1:0] start;
    logic [1:0] coin;
    byte_t      dswa;
    byte_t      dswb;
    logic       vblank_n;
    logic       dma_n;

    entry_t table_q[$];
    integer seed;
    int     rand_val;
    int     cycles = 0;

    f2_bus_top UUT (
        .clk, .reset, .game,
        .as_n, .rw, .ds_n, .addr, .fc, .wdata, .rdata, .dtack_n, .ipl_n,
        .joystick_p1, .joystick_p2, .start, .coin, .dswa, .dswb,
        .vblank_n, .dma_n
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
            stop_run($sformatf("Timeout: test did not finish within %0d clock cycles", cycles));
    end

    //////////////////////////////////////////////////
    // Expected values

    function automatic word_addr_t map_addr(byte_t base, logic [14:0] ofs);
        return {base, ofs};
    endfunction

    function automatic byte_t player_byte(logic st, joy_t j);
        return ~{st, j[6], j[5], j[4], j[0], j[1], j[2], j[3]};
    endfunction

    function automatic bus_data_t port_expect(game_t g, logic [3:0] ofs);
        logic [3:0] eff;
        byte_t      b;
        eff = (g == GAME_GROWL) ? (ofs ^ 4'd1) : ofs;   // Growl swaps port pairs
        case (eff)
            PORT_DSWA: b = ~dswa;
            PORT_DSWB: b = ~dswb;
            PORT_P1:   b = player_byte(start[0], joystick_p1);
            PORT_P2:   b = player_byte(start[1], joystick_p2);
            PORT_SYS:  b = ~{2'b00, coin, start, 2'b00};
            default:   b = 8'hFF;
        endcase
        return {b, b};
    endfunction

    //////////////////////////////////////////////////
    // Tasks

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic add_entry(input op_t op, input game_t g, input word_addr_t a,
                             input lane_n_t ds, input bus_data_t wd, input bus_data_t exp);
        entry_t e;
        e = '{op: op, game: g, addr: a, ds_n: ds, wdata: wd, expected: exp};
        table_q.push_back(e);
    endtask

    task automatic check_ipl(input logic [2:0] exp, input string what);
        assert (ipl_n == exp)
        else stop_run($sformatf("ERR %0t: ipl_n %b after %s, expected %b",
                                $time, ipl_n, what, exp));
    endtask

    // One 68000 cycle entered and left on a falling edge
    task automatic run_cycle(input entry_t e, output bus_data_t data);
        int lat;
        game  = e.game;
        addr  = e.addr;
        ds_n  = e.ds_n;
        wdata = e.wdata;
        rw    = (e.op != OP_WRITE);
        fc    = (e.op == OP_IACK) ? 3'd7 : 3'd5;
        @(negedge clk);
        as_n = 1'b0;
        @(posedge clk);     // Start edge
        lat = 0;
        @(negedge clk);
        while (dtack_n && lat < DTACK_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        assert (lat == 1 && !dtack_n)
        else stop_run($sformatf("ERR %0t: dtack_n answered %0d cycles after start, expected 1",
                                $time, lat));
        data = rdata;
        as_n = 1'b1;
        @(negedge clk);
        assert (dtack_n)
        else stop_run($sformatf("ERR %0t: dtack_n still low after as_n rose", $time));
    endtask

    task automatic build_table();
        // Byte lanes merge into one word
        add_entry(OP_WRITE, GAME_FINALB, map_addr(8'h10, 15'h0040), 2'b00, 16'h1234, 16'h0);
        add_entry(OP_WRITE, GAME_FINALB, map_addr(8'h10, 15'h0040), 2'b01, 16'hAB55, 16'h0);
        add_entry(OP_WRITE, GAME_FINALB, map_addr(8'h10, 15'h0040), 2'b10, 16'h66CD, 16'h0);
        add_entry(OP_READ,  GAME_FINALB, map_addr(8'h10, 15'h0040), 2'b00, 16'h0, 16'hABCD);
        add_entry(OP_WRITE, GAME_GROWL,  map_addr(8'h10, 15'h0041), 2'b00, 16'hBEEF, 16'h0);
        add_entry(OP_WRITE, GAME_GROWL,  map_addr(8'h10, 15'h0041), 2'b01, 16'h1255, 16'h0);
        add_entry(OP_READ,  GAME_GROWL,  map_addr(8'h10, 15'h0041), 2'b00, 16'h0, 16'h12EF);
        add_entry(OP_WRITE, GAME_NINJAK, map_addr(8'h20, 15'h0042), 2'b00, 16'hCA00, 16'h0);
        add_entry(OP_WRITE, GAME_NINJAK, map_addr(8'h20, 15'h0042), 2'b10, 16'h66FE, 16'h0);
        add_entry(OP_READ,  GAME_NINJAK, map_addr(8'h20, 15'h0042), 2'b00, 16'h0, 16'hCAFE);
        // Finalb work base is unmapped on Ninjak
        add_entry(OP_WRITE, GAME_NINJAK, map_addr(8'h10, 15'h0042), 2'b00, 16'hDEAD, 16'h0);
        add_entry(OP_READ,  GAME_NINJAK, map_addr(8'h10, 15'h0042), 2'b00, 16'h0, 16'h0000);
        add_entry(OP_READ,  GAME_NINJAK, map_addr(8'h20, 15'h0042), 2'b00, 16'h0, 16'hCAFE);
        add_entry(OP_READ,  GAME_FINALB, map_addr(8'h20, 15'h0042), 2'b00, 16'h0, 16'h0000);
        // Unmapped space
        add_entry(OP_WRITE, GAME_FINALB, map_addr(8'h50, 15'h0040), 2'b00, 16'h5555, 16'h0);
        add_entry(OP_READ,  GAME_FINALB, map_addr(8'h50, 15'h0040), 2'b00, 16'h0, 16'h0000);
        add_entry(OP_READ,  GAME_FINALB, map_addr(8'h10, 15'h0040), 2'b00, 16'h0, 16'hABCD);
        for (int i = 0; i < 6; i++)
            add_entry(OP_PORT, GAME_FINALB, map_addr(8'h30, 15'(i)), 2'b00, 16'h0, 16'h0);
        for (int i = 0; i < 4; i++)
            add_entry(OP_PORT, GAME_GROWL, map_addr(8'h30, 15'(i)), 2'b00, 16'h0, 16'h0);
        add_entry(OP_PORT, GAME_NINJAK, map_addr(8'hB0, 15'd2), 2'b00, 16'h0, 16'h0);
        add_entry(OP_PORT, GAME_NINJAK, map_addr(8'hB0, 15'd4), 2'b00, 16'h0, 16'h0);
        // Interrupts with ipl_n as the inverted level
        add_entry(OP_VBL,  GAME_FINALB, 23'h0, 2'b11, 16'h0, 16'h0002);
        add_entry(OP_DMA,  GAME_FINALB, 23'h0, 2'b11, 16'h0, 16'h0001);
        add_entry(OP_IACK, GAME_FINALB, {20'hFFFFF, 3'd6}, 2'b10, 16'h0, 16'h0002);
        add_entry(OP_IACK, GAME_FINALB, {20'hFFFFF, 3'd5}, 2'b10, 16'h0, 16'h0007);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        entry_t    e;
        bus_data_t data;
        seed     = 20600;
        reset    = 1'b1;
        game     = GAME_FINALB;
        as_n     = 1'b1;
        rw       = 1'b1;
        ds_n     = 2'b11;
        addr     = '0;
        fc       = 3'd5;
        wdata    = '0;
        start    = 2'b10;
        coin     = 2'b01;
        dswa     = 8'hC3;
        dswb     = 8'h5A;
        vblank_n = 1'b1;
        dma_n    = 1'b1;
        rand_val = $random(seed);
        joystick_p1 = rand_val[9:0];
        rand_val = $random(seed);
        joystick_p2 = rand_val[9:0];

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (dtack_n)
        else stop_run($sformatf("ERR %0t: dtack_n low after reset", $time));
        check_ipl(3'b111, "reset");

        build_table();
        foreach (table_q[i]) begin
            e = table_q[i];
            case (e.op)
                OP_WRITE: run_cycle(e, data);
                OP_READ: begin
                    run_cycle(e, data);
                    assert (data == e.expected)
                    else stop_run($sformatf("ERR %0t: read %h gave %h, expected %h",
                                            $time, e.addr, data, e.expected));
                end
                OP_PORT: begin
                    run_cycle(e, data);
                    assert (data == port_expect(e.game, e.addr[3:0]))
                    else stop_run($sformatf("ERR %0t: port %0d game %s gave %h, expected %h",
                                            $time, e.addr[3:0], e.game.name(), data,
                                            port_expect(e.game, e.addr[3:0])));
                end
                OP_IACK: begin
                    run_cycle(e, data);
                    assert (data == 16'h0000)
                    else stop_run($sformatf("ERR %0t: acknowledge read gave %h", $time, data));
                    check_ipl(e.expected[2:0], "acknowledge");
                end
                OP_VBL: begin
                    vblank_n = 1'b0;
                    @(negedge clk);
                    check_ipl(e.expected[2:0], "vblank fall");
                    vblank_n = 1'b1;
                    @(negedge clk);
                end
                OP_DMA: begin
                    dma_n = 1'b0;
                    @(negedge clk);
                    dma_n = 1'b1;
                    @(negedge clk);
                    check_ipl(e.expected[2:0], "dma rise");
                end
                default: stop_run("Unknown operation in the stimulus table");
            endcase
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
f2_pkg.sv
cpu_bus_if.sv
region_decoder.sv
work_ram.sv
input_ports.sv
irq_ctrl.sv
f2_bus_top.sv
tb_f2_bus.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_f2_bus -o tb_sim

out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q '^=== PASS ===$'; then
    exit 0
fi
exit 1
